/* source/axird_pkg.sv */
// ----------------------------------------------------------------------
// Shared AXI encodings and fixed field widths for the read subordinate
// Reserved burst code is accepted and handled like FIXED
// EXOKAY and DECERR are listed for completeness and never produced
// ----------------------------------------------------------------------

package axird_pkg;

    // ------------------------------------------------------------------
    // Fixed AXI field widths
    // ------------------------------------------------------------------

    // AxLEN carries the beat count minus one
    localparam int AXI_LEN_W = 8;

    // AxSIZE is log2 of the bytes per beat
    localparam int AXI_SIZE_W = 3;

    // ------------------------------------------------------------------
    // Burst kinds
    // ------------------------------------------------------------------

    typedef enum logic [1:0] {
        AXI_BURST_FIXED = 2'b00,
        AXI_BURST_INCR  = 2'b01,
        AXI_BURST_WRAP  = 2'b10,
        // Not legal on the bus, decoded as FIXED
        AXI_BURST_RSVD  = 2'b11
    } axi_burst_e;

    // ------------------------------------------------------------------
    // Read response codes
    // ------------------------------------------------------------------

    typedef enum logic [1:0] {
        AXI_RESP_OKAY   = 2'b00,
        AXI_RESP_EXOKAY = 2'b01,
        AXI_RESP_SLVERR = 2'b10,
        AXI_RESP_DECERR = 2'b11
    } axi_resp_e;

endpackage

/* source/axird_burst_addr.sv */
// ----------------------------------------------------------------------
// Next beat address for FIXED, INCR and WRAP bursts
// WRAP expects len+1 of 2, 4, 8 or 16 and a size-aligned start address
// Purely combinational, no 4KB boundary check
// ----------------------------------------------------------------------
`timescale 1ns/1ns

module axird_burst_addr #(
    parameter int AW = 32
) (
    input  logic [AW-1:0]                    i_addr,
    input  logic [axird_pkg::AXI_SIZE_W-1:0] i_size,
    input  logic [axird_pkg::AXI_LEN_W-1:0]  i_len,
    input  axird_pkg::axi_burst_e            i_burst,
    output logic [AW-1:0]                    o_next_addr
);

    // Bytes moved per beat
    logic [AW-1:0] size_bytes;
    // Current address pulled down to the transfer size
    logic [AW-1:0] aligned_addr;
    logic [AW-1:0] incr_addr;
    // Low bits that move inside the wrap region
    logic [AW-1:0] wrap_mask;
    logic [AW-1:0] wrap_addr;

    assign size_bytes   = AW'(1) << i_size;
    assign aligned_addr = i_addr & ~(size_bytes - AW'(1));

    // Narrow unaligned starts snap to the next size boundary
    assign incr_addr = aligned_addr + size_bytes;

    // Region is (len+1) beats of size_bytes each, a power of two
    assign wrap_mask = ((AW'(i_len) + AW'(1)) << i_size) - AW'(1);

    // Upper bits stay fixed, lower bits roll over inside the region
    assign wrap_addr = (i_addr & ~wrap_mask) | (incr_addr & wrap_mask);

    // ------------------------------------------------------------------
    // Burst select
    // ------------------------------------------------------------------

    always_comb begin
        case (i_burst)
            axird_pkg::AXI_BURST_INCR: begin
                o_next_addr = incr_addr;
            end
            axird_pkg::AXI_BURST_WRAP: begin
                o_next_addr = wrap_addr;
            end
            // FIXED and the reserved code keep the address
            default: begin
                o_next_addr = i_addr;
            end
        endcase
    end

endmodule

/* source/axird_req_issue.sv */
// ----------------------------------------------------------------------
// Address stage: takes one AR request at a time and walks its beats
// Component address is word aligned, the byte offset stays internal
// dv waits for room in every skid stage so no returning beat is lost
// ----------------------------------------------------------------------
`timescale 1ns/1ns

module axird_req_issue #(
    parameter int AW = 32,
    parameter int DW = 32,
    parameter int IW = 4
) (
    input  logic                             clk,
    input  logic                             rst_n,
    // AR channel
    input  logic                             i_arvalid,
    output logic                             o_arready,
    input  logic [AW-1:0]                    i_araddr,
    input  logic [1:0]                       i_arburst,
    input  logic [axird_pkg::AXI_SIZE_W-1:0] i_arsize,
    input  logic [axird_pkg::AXI_LEN_W-1:0]  i_arlen,
    input  logic [IW-1:0]                    i_arid,
    // Room report from the response pipe
    input  logic                             i_pipe_room,
    // Component request port
    input  logic                             i_hld,
    output logic                             o_dv,
    output logic [AW-1:0]                    o_addr,
    output logic [IW-1:0]                    o_id,
    // Issued beat context toward the delay line
    output logic                             o_beat_fire,
    output logic [IW-1:0]                    o_beat_id,
    output logic                             o_beat_last
);

    // Byte lanes per data word
    localparam int BC = DW / 8;

    // ------------------------------------------------------------------
    // Transaction state
    // ------------------------------------------------------------------

    logic                                txn_active;
    logic [AW-1:0]                       txn_addr;
    axird_pkg::axi_burst_e               txn_burst;
    logic [axird_pkg::AXI_SIZE_W-1:0]    txn_size;
    logic [axird_pkg::AXI_LEN_W-1:0]     txn_len;
    logic [IW-1:0]                       txn_id;
    // Beats still to issue after the current one
    logic [axird_pkg::AXI_LEN_W-1:0]     txn_cnt;
    logic [AW-1:0]                       next_addr;
    logic                                ar_fire;
    logic                                final_beat;

    // Free, or about to become free on the final issued beat
    assign o_arready = !txn_active || final_beat;
    assign ar_fire   = i_arvalid && o_arready;

    // Request only with a slot guaranteed for the returning data
    assign o_dv        = txn_active && i_pipe_room;
    assign o_beat_fire = o_dv && !i_hld;
    assign o_beat_last = (txn_cnt == '0);
    assign o_beat_id   = txn_id;
    assign final_beat  = o_beat_fire && o_beat_last;

    // Active means beats remain to issue, data may still be in flight
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            txn_active <= 1'b0;
        end else if (ar_fire) begin
            txn_active <= 1'b1;
        end else if (final_beat) begin
            txn_active <= 1'b0;
        end
    end

    // Down-counter parks at zero after the last beat
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            txn_cnt <= '0;
        end else if (ar_fire) begin
            txn_cnt <= i_arlen;
        end else if (o_beat_fire && (txn_cnt != '0)) begin
            txn_cnt <= txn_cnt - 1'b1;
        end
    end

    // Request fields, a new request wins over the last beat advance
    always_ff @(posedge clk) begin
        if (ar_fire) begin
            txn_addr  <= i_araddr;
            txn_burst <= axird_pkg::axi_burst_e'(i_arburst);
            txn_size  <= i_arsize;
            txn_len   <= i_arlen;
            txn_id    <= i_arid;
        end else if (o_beat_fire) begin
            txn_addr  <= next_addr;
        end
    end

    // ------------------------------------------------------------------
    // Address generation
    // ------------------------------------------------------------------

    // Full byte address feeds the walk so narrow beats step correctly
    axird_burst_addr #(
        .AW (AW)
    ) u_burst_addr (
        .i_addr      (txn_addr),
        .i_size      (txn_size),
        .i_len       (txn_len),
        .i_burst     (txn_burst),
        .o_next_addr (next_addr)
    );

    // Component sees whole words only
    assign o_addr = txn_addr & ~AW'(BC - 1);
    assign o_id   = txn_id;

    // Master must keep an unaccepted AR request up
    ar_hold_check: assert property (
        @(posedge clk) disable iff (!rst_n)
        (i_arvalid && !o_arready) |=> i_arvalid
    );

endmodule

/* source/axird_ctx_delay.sv */
// ----------------------------------------------------------------------
// Fixed delay of C_LAT cycles for issued beat context
// Lines ID and last up with the component data, C_LAT of 0 is wires
// ----------------------------------------------------------------------
`timescale 1ns/1ns

module axird_ctx_delay #(
    parameter int IW    = 4,
    parameter int C_LAT = 2
) (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          i_valid,
    input  logic [IW-1:0] i_id,
    input  logic          i_last,
    output logic          o_valid,
    output logic [IW-1:0] o_id,
    output logic          o_last
);

    if (C_LAT == 0) begin : g_wire

        // Component answers in the same cycle
        assign o_valid = i_valid;
        assign o_id    = i_id;
        assign o_last  = i_last;

    end else begin : g_shift

        logic [C_LAT-1:0] vld_sr;
        logic [IW-1:0]    id_sr [C_LAT];
        logic [C_LAT-1:0] last_sr;

        // Valid bits are the only control here
        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                vld_sr <= '0;
            end else begin
                vld_sr[0] <= i_valid;
                for (int k = 1; k < C_LAT; k++) begin
                    vld_sr[k] <= vld_sr[k-1];
                end
            end
        end

        // ID and last ride along with their valid bit
        always_ff @(posedge clk) begin
            id_sr[0]   <= i_id;
            last_sr[0] <= i_last;
            for (int k = 1; k < C_LAT; k++) begin
                id_sr[k]   <= id_sr[k-1];
                last_sr[k] <= last_sr[k-1];
            end
        end

        assign o_valid = vld_sr[C_LAT-1];
        assign o_id    = id_sr[C_LAT-1];
        assign o_last  = last_sr[C_LAT-1];

    end

endmodule

/* source/axird_skid_stage.sv */
// ----------------------------------------------------------------------
// One-entry skid buffer, combinational pass-through while empty
// Ready drops only while the held entry waits for the output side
// ----------------------------------------------------------------------
`timescale 1ns/1ns

module axird_skid_stage #(
    parameter int W = 8
) (
    input  logic         clk,
    input  logic         rst_n,
    // Upstream side
    input  logic         i_valid,
    output logic         o_ready,
    input  logic [W-1:0] i_data,
    // Downstream side
    output logic         o_valid,
    input  logic         i_ready,
    output logic [W-1:0] o_data
);

    // Entry parked while the output is stalled
    logic         skid_valid;
    logic [W-1:0] skid_data;

    // Accept only with the skid slot free
    assign o_ready = !skid_valid;

    // Held entry goes out first, otherwise pass straight through
    assign o_valid = i_valid || skid_valid;
    assign o_data  = skid_valid ? skid_data : i_data;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            skid_valid <= 1'b0;
        end else if (skid_valid) begin
            // Drain once downstream takes it
            if (i_ready) begin
                skid_valid <= 1'b0;
            end
        end else if (i_valid && !i_ready) begin
            skid_valid <= 1'b1;
        end
    end

    // Capture the passing word when it was not taken
    always_ff @(posedge clk) begin
        if (!skid_valid && i_valid && !i_ready) begin
            skid_data <= i_data;
        end
    end

    // Stalled output must not change or vanish
    out_hold_check: assert property (
        @(posedge clk) disable iff (!rst_n)
        (o_valid && !i_ready) |=> (o_valid && $stable(o_data))
    );

endmodule

/* source/axird_resp_pipe.sv */
// ----------------------------------------------------------------------
// Response side: packs data with ID, response and last into C_LAT+1
// skid stages in series ending on the R channel
// o_room is high only when every stage can take one more beat
// ----------------------------------------------------------------------
`timescale 1ns/1ns

module axird_resp_pipe #(
    parameter int DW    = 32,
    parameter int IW    = 4,
    parameter int C_LAT = 2
) (
    input  logic          clk,
    input  logic          rst_n,
    // Delayed beat context
    input  logic          i_valid,
    input  logic [IW-1:0] i_id,
    input  logic          i_last,
    // Component data, sampled with i_valid
    input  logic [DW-1:0] i_rdata,
    input  logic          i_err,
    // Back to the address stage
    output logic          o_room,
    // R channel
    output logic          o_rvalid,
    input  logic          i_rready,
    output logic [DW-1:0] o_rdata,
    output logic [IW-1:0] o_rid,
    output logic [1:0]    o_rresp,
    output logic          o_rlast
);

    // Data, ID, 2-bit response and last
    localparam int PW = DW + IW + 3;

    // ------------------------------------------------------------------
    // Entry packing
    // ------------------------------------------------------------------

    axird_pkg::axi_resp_e resp_in;
    // Index 0 is the entry, C_LAT+1 is the R channel
    logic [C_LAT+1:0]     st_valid;
    logic [C_LAT+1:0]     st_ready;
    logic [PW-1:0]        st_data [C_LAT+2];

    assign resp_in = i_err ? axird_pkg::AXI_RESP_SLVERR : axird_pkg::AXI_RESP_OKAY;

    assign st_valid[0] = i_valid;
    assign st_data[0]  = {i_rdata, i_id, resp_in, i_last};

    // ------------------------------------------------------------------
    // Skid chain
    // ------------------------------------------------------------------

    // One stage per beat that can be in flight when rready drops
    for (genvar k = 0; k <= C_LAT; k++) begin : g_stage
        axird_skid_stage #(
            .W (PW)
        ) u_skid (
            .clk     (clk),
            .rst_n   (rst_n),
            .i_valid (st_valid[k]),
            .o_ready (st_ready[k]),
            .i_data  (st_data[k]),
            .o_valid (st_valid[k+1]),
            .i_ready (st_ready[k+1]),
            .o_data  (st_data[k+1])
        );
    end

    assign st_ready[C_LAT+1] = i_rready;

    // All stages free of a parked entry
    assign o_room = &st_ready[C_LAT:0];

    assign o_rvalid = st_valid[C_LAT+1];
    assign {o_rdata, o_rid, o_rresp, o_rlast} = st_data[C_LAT+1];

    // Address stage room gating must keep the entry from overflowing
    entry_drop_check: assert property (
        @(posedge clk) disable iff (!rst_n)
        st_valid[0] |-> st_ready[0]
    );

endmodule

/* source/axird_top.sv */
// ----------------------------------------------------------------------
// AXI read subordinate top, one AR request in service at a time
// Component must return data exactly C_LAT cycles after dv without hld
// Responses come back in request order, no exclusive access support
// ----------------------------------------------------------------------
`timescale 1ns/1ns

module axird_top #(
    parameter int AW    = 32,
    parameter int DW    = 32,
    parameter int IW    = 4,
    parameter int C_LAT = 2
) (
    input  logic                             clk,
    input  logic                             rst_n,
    // AR channel
    input  logic                             i_arvalid,
    output logic                             o_arready,
    input  logic [AW-1:0]                    i_araddr,
    input  logic [1:0]                       i_arburst,
    input  logic [axird_pkg::AXI_SIZE_W-1:0] i_arsize,
    input  logic [axird_pkg::AXI_LEN_W-1:0]  i_arlen,
    input  logic [IW-1:0]                    i_arid,
    // R channel
    output logic                             o_rvalid,
    input  logic                             i_rready,
    output logic [DW-1:0]                    o_rdata,
    output logic [IW-1:0]                    o_rid,
    output logic [1:0]                       o_rresp,
    output logic                             o_rlast,
    // Component port
    output logic                             o_dv,
    output logic [AW-1:0]                    o_addr,
    output logic [IW-1:0]                    o_id,
    input  logic                             i_hld,
    input  logic [DW-1:0]                    i_rdata,
    input  logic                             i_err
);

    logic          beat_fire;
    logic [IW-1:0] beat_id;
    logic          beat_last;
    logic          dly_valid;
    logic [IW-1:0] dly_id;
    logic          dly_last;
    logic          pipe_room;

    axird_req_issue #(
        .AW (AW),
        .DW (DW),
        .IW (IW)
    ) u_req_issue (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_arvalid   (i_arvalid),
        .o_arready   (o_arready),
        .i_araddr    (i_araddr),
        .i_arburst   (i_arburst),
        .i_arsize    (i_arsize),
        .i_arlen     (i_arlen),
        .i_arid      (i_arid),
        .i_pipe_room (pipe_room),
        .i_hld       (i_hld),
        .o_dv        (o_dv),
        .o_addr      (o_addr),
        .o_id        (o_id),
        .o_beat_fire (beat_fire),
        .o_beat_id   (beat_id),
        .o_beat_last (beat_last)
    );

    // Beat context waits out the component latency
    axird_ctx_delay #(
        .IW    (IW),
        .C_LAT (C_LAT)
    ) u_ctx_delay (
        .clk     (clk),
        .rst_n   (rst_n),
        .i_valid (beat_fire),
        .i_id    (beat_id),
        .i_last  (beat_last),
        .o_valid (dly_valid),
        .o_id    (dly_id),
        .o_last  (dly_last)
    );

    axird_resp_pipe #(
        .DW    (DW),
        .IW    (IW),
        .C_LAT (C_LAT)
    ) u_resp_pipe (
        .clk      (clk),
        .rst_n    (rst_n),
        .i_valid  (dly_valid),
        .i_id     (dly_id),
        .i_last   (dly_last),
        .i_rdata  (i_rdata),
        .i_err    (i_err),
        .o_room   (pipe_room),
        .o_rvalid (o_rvalid),
        .i_rready (i_rready),
        .o_rdata  (o_rdata),
        .o_rid    (o_rid),
        .o_rresp  (o_rresp),
        .o_rlast  (o_rlast)
    );

endmodule

/* sim/tb_axird_cases.svh */
// ----------------------------------------------------------------------
// Read burst cases and the expected beat rule for tb_axird
// Expected word address assumes a 32-bit data bus
// WRAP rows start size aligned with len+1 of 2, 4, 8 or 16
// ----------------------------------------------------------------------
`ifndef TB_AXIRD_CASES_SVH
`define TB_AXIRD_CASES_SVH

localparam int NCASES = 11;

// Short names for the table rows
localparam axird_pkg::axi_burst_e B_FIXED = axird_pkg::AXI_BURST_FIXED;
localparam axird_pkg::axi_burst_e B_INCR  = axird_pkg::AXI_BURST_INCR;
localparam axird_pkg::axi_burst_e B_WRAP  = axird_pkg::AXI_BURST_WRAP;
localparam logic [1:0]            RESP_OK  = 2'b00;
localparam logic [1:0]            RESP_ERR = 2'b10;

string                 case_name  [NCASES];
logic [3:0]            case_id    [NCASES];
logic [31:0]           case_addr  [NCASES];
logic [7:0]            case_len   [NCASES];
logic [2:0]            case_size  [NCASES];
axird_pkg::axi_burst_e case_burst [NCASES];
bit                    case_stall [NCASES];
bit                    case_bp    [NCASES];
logic [1:0]            case_resp  [NCASES];

task automatic set_case(input int idx, input string name, input int id, input logic [31:0] addr,
                        input int len, input int size, input axird_pkg::axi_burst_e burst,
                        input bit stall, input bit bp, input logic [1:0] resp);
    case_name[idx]  = name;
    case_id[idx]    = 4'(id);
    case_addr[idx]  = addr;
    case_len[idx]   = 8'(len);
    case_size[idx]  = 3'(size);
    case_burst[idx] = burst;
    case_stall[idx] = stall;
    case_bp[idx]    = bp;
    case_resp[idx]  = resp;
endtask

// Columns are index, name, ID, address, len, size, burst, stall, back-pressure and response
task automatic load_cases();
    set_case(0, "incr_full", 1, 32'h0000_1000, 7, 2, B_INCR, 0, 0, RESP_OK);
    set_case(1, "wrap_mid", 2, 32'h0000_2038, 3, 2, B_WRAP, 0, 0, RESP_OK);
    set_case(2, "fixed_word", 3, 32'h0000_3010, 4, 2, B_FIXED, 0, 0, RESP_OK);
    set_case(3, "incr_byte", 4, 32'h0000_4104, 7, 0, B_INCR, 0, 0, RESP_OK);
    set_case(4, "err_region", 5, 32'h8000_0040, 3, 2, B_INCR, 0, 0, RESP_ERR);
    set_case(5, "wrap_half", 6, 32'h0000_5006, 7, 1, B_WRAP, 0, 0, RESP_OK);
    // Random stalls from here on with requests queued behind each other
    set_case(6, "rand_incr", 7, 32'h0000_6000, 15, 2, B_INCR, 1, 1, RESP_OK);
    set_case(7, "rand_wrap", 8, 32'h0000_7024, 7, 2, B_WRAP, 1, 1, RESP_OK);
    set_case(8, "rand_err", 9, 32'h8000_1100, 5, 2, B_INCR, 1, 1, RESP_ERR);
    set_case(9, "rand_byte", 10, 32'h0000_9003, 5, 0, B_INCR, 1, 1, RESP_OK);
    set_case(10, "rand_single", 11, 32'h0000_a000, 0, 2, B_INCR, 1, 1, RESP_OK);
endtask

// Byte address of one beat in closed form over the beat index
function automatic logic [31:0] beat_addr(input logic [31:0] start, input logic [2:0] size,
                                          input logic [7:0] len,
                                          input axird_pkg::axi_burst_e burst, input int beat);
    logic [31:0] nbytes;
    logic [31:0] first;
    logic [31:0] region;
    logic [31:0] base;
    nbytes = 32'd1 << size;
    first  = start & ~(nbytes - 32'd1);
    // Wrap region holds every beat of the burst
    region = (32'(len) + 32'd1) * nbytes;
    base   = start & ~(region - 32'd1);
    case (burst)
        axird_pkg::AXI_BURST_INCR: begin
            beat_addr = (beat == 0) ? start : first + 32'(beat) * nbytes;
        end
        axird_pkg::AXI_BURST_WRAP: begin
            beat_addr = base + ((first - base + 32'(beat) * nbytes) % region);
        end
        default: begin
            beat_addr = start;
        end
    endcase
endfunction

// Queue every beat of one row in issue order, which is also R order
task automatic push_expected(input int idx);
    logic [31:0] word;
    for (int k = 0; k <= int'(case_len[idx]); k++) begin
        word = beat_addr(case_addr[idx], case_size[idx], case_len[idx], case_burst[idx], k);
        word = word & ~32'h3;
        iss_addr.push_back(word);
        iss_id.push_back(case_id[idx]);
        iss_tag.push_back($sformatf("%s beat %0d", case_name[idx], k));
        exp_data.push_back(word ^ PATTERN);
        exp_id.push_back(case_id[idx]);
        exp_resp.push_back(case_resp[idx]);
        exp_last.push_back(k == int'(case_len[idx]));
        exp_name.push_back(case_name[idx]);
        exp_beat.push_back(k);
    end
endtask

`endif

/* sim/tb_axird.sv */
// ----------------------------------------------------------------------
// Testbench for the AXI read subordinate with C_LAT fixed at 2
// Component model needs C_LAT of at least 1
// Component model answers C_LAT cycles after each issued word address
// Error region is any address with the top bit set
// ----------------------------------------------------------------------
`timescale 1ns/1ns

module tb_axird;

    localparam int AW    = 32;
    localparam int DW    = 32;
    localparam int IW    = 4;
    localparam int C_LAT = 2;
    // Model data is the word address scrambled by this
    localparam logic [31:0] PATTERN       = 32'ha5c3_96e1;
    localparam int          AR_TIMEOUT    = 200;
    localparam int          DRAIN_TIMEOUT = 3000;

    logic          clk;
    logic          rst_n;
    logic          i_arvalid;
    logic          o_arready;
    logic [AW-1:0] i_araddr;
    logic [1:0]    i_arburst;
    logic [2:0]    i_arsize;
    logic [7:0]    i_arlen;
    logic [IW-1:0] i_arid;
    logic          o_rvalid;
    logic          i_rready;
    logic [DW-1:0] o_rdata;
    logic [IW-1:0] o_rid;
    logic [1:0]    o_rresp;
    logic          o_rlast;
    logic          o_dv;
    logic [AW-1:0] o_addr;
    logic [IW-1:0] o_id;
    logic          i_hld;
    logic [DW-1:0] i_rdata;
    logic          i_err;

    // Expected component requests in issue order
    logic [31:0]   iss_addr [$];
    logic [IW-1:0] iss_id   [$];
    string         iss_tag  [$];

    // Expected R beats in arrival order
    logic [31:0]   exp_data [$];
    logic [IW-1:0] exp_id   [$];
    logic [1:0]    exp_resp [$];
    bit            exp_last [$];
    string         exp_name [$];
    int            exp_beat [$];

    int            check_count;
    int            mismatch_count;
    int            other_errors;
    bit            timed_out;
    bit            stall_mode;
    bit            bp_mode;
    logic [31:0]   rng_state;
    // Component model latency line
    logic [AW-1:0] addr_now;
    bit            fire_now;
    logic [AW-1:0] lat_addr [C_LAT];
    bit            lat_vld  [C_LAT];

    `include "tb_axird_cases.svh"

    axird_top #(
        .AW    (AW),
        .DW    (DW),
        .IW    (IW),
        .C_LAT (C_LAT)
    ) UUT (
        .clk (clk), .rst_n (rst_n),
        .i_arvalid (i_arvalid), .o_arready (o_arready), .i_araddr (i_araddr),
        .i_arburst (i_arburst), .i_arsize (i_arsize), .i_arlen (i_arlen), .i_arid (i_arid),
        .o_rvalid (o_rvalid), .i_rready (i_rready), .o_rdata (o_rdata), .o_rid (o_rid),
        .o_rresp (o_rresp), .o_rlast (o_rlast),
        .o_dv (o_dv), .o_addr (o_addr), .o_id (o_id), .i_hld (i_hld),
        .i_rdata (i_rdata), .i_err (i_err)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] v;
        v = x;
        v = v ^ (v << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        if (expected !== actual) begin
            mismatch_count++;
            $display("FAIL %s expected %h actual %h", name, expected, actual);
        end
    endtask

    // ------------------------------------------------------------------
    // Component model and random stall sources driven just after each edge
    // ------------------------------------------------------------------

    always @(posedge clk) begin
        #1;
        for (int k = C_LAT - 1; k > 0; k--) begin
            lat_addr[k] = lat_addr[k-1];
            lat_vld[k]  = lat_vld[k-1];
        end
        lat_addr[0] = addr_now;
        lat_vld[0]  = fire_now;
        // Slots without an accepted request return no data
        i_rdata     = lat_vld[C_LAT-1] ? (lat_addr[C_LAT-1] ^ PATTERN) : '0;
        i_err       = lat_vld[C_LAT-1] && lat_addr[C_LAT-1][AW-1];
        rng_state   = xorshift32(rng_state);
        // Roughly 3 in 8 cycles stalled and 3 in 8 without rready
        i_hld    = stall_mode && (rng_state[2:0] < 3'd3);
        i_rready = !bp_mode || (rng_state[6:4] >= 3'd3);
    end

    // Component takes a request only on dv without hld
    always @(negedge clk) begin : issue_monitor
        string tag;
        fire_now = rst_n && o_dv && !i_hld;
        addr_now = o_addr;
        if (fire_now) begin
            if (iss_addr.size() == 0) begin
                other_errors++;
                $display("ERROR: component request for %h with no beat left to issue", o_addr);
            end else begin
                tag = iss_tag.pop_front();
                check_value({tag, " addr"}, iss_addr.pop_front(), o_addr);
                check_value({tag, " id"}, 32'(iss_id.pop_front()), 32'(o_id));
            end
        end
    end

    // Outputs settle by the falling edge so a beat seen here transfers next edge
    always @(negedge clk) begin : r_monitor
        string tag;
        if (rst_n && o_rvalid && i_rready) begin
            if (exp_data.size() == 0) begin
                other_errors++;
                $display("ERROR: R beat with ID %0h arrived with none expected", o_rid);
            end else begin
                tag = $sformatf("%s beat %0d", exp_name.pop_front(), exp_beat.pop_front());
                check_value({tag, " rdata"}, exp_data.pop_front(), o_rdata);
                check_value({tag, " rid"}, 32'(exp_id.pop_front()), 32'(o_rid));
                check_value({tag, " rresp"}, 32'(exp_resp.pop_front()), 32'(o_rresp));
                check_value({tag, " rlast"}, 32'(exp_last.pop_front()), 32'(o_rlast));
            end
        end
    end

    // Present one row on AR and hold it until the handshake
    task automatic apply_request(input int idx);
        int waited;
        bit accepted;
        waited   = 0;
        accepted = 1'b0;
        @(negedge clk);
        stall_mode = case_stall[idx];
        bp_mode    = case_bp[idx];
        push_expected(idx);
        @(posedge clk);
        #1;
        i_arid    = case_id[idx];
        i_araddr  = case_addr[idx];
        i_arlen   = case_len[idx];
        i_arsize  = case_size[idx];
        i_arburst = case_burst[idx];
        i_arvalid = 1'b1;
        while (!accepted && waited < AR_TIMEOUT) begin
            @(negedge clk);
            if (o_arready) begin
                accepted = 1'b1;
            end else begin
                waited++;
            end
        end
        @(posedge clk);
        #1;
        i_arvalid = 1'b0;
        if (!accepted) begin
            other_errors++;
            timed_out = 1'b1;
            $display("ERROR: arready never came for request %s", case_name[idx]);
        end
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (exp_data.size() != 0 && waited < DRAIN_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (exp_data.size() != 0) begin
            other_errors++;
            timed_out = 1'b1;
            $display("ERROR: timed out with %0d R beats still missing", exp_data.size());
        end
    endtask

    initial begin
        clk            = 1'b0;
        rst_n          = 1'b0;
        i_arvalid      = 1'b0;
        i_araddr       = '0;
        i_arburst      = '0;
        i_arsize       = '0;
        i_arlen        = '0;
        i_arid         = '0;
        i_rready       = 1'b1;
        i_hld          = 1'b0;
        i_rdata        = '0;
        i_err          = 1'b0;
        addr_now       = '0;
        fire_now       = 1'b0;
        rng_state      = 32'hfed1;
        check_count    = 0;
        mismatch_count = 0;
        other_errors   = 0;
        timed_out      = 1'b0;
        stall_mode     = 1'b0;
        bp_mode        = 1'b0;
        for (int k = 0; k < C_LAT; k++) begin
            lat_addr[k] = '0;
            lat_vld[k]  = 1'b0;
        end
        load_cases();
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;
        for (int i = 0; i < NCASES && !timed_out; i++) begin
            apply_request(i);
            // Directed rows finish alone while random rows pile up
            if (!case_stall[i] && !case_bp[i]) begin
                wait_drain();
            end
        end
        if (!timed_out) begin
            wait_drain();
        end
        @(negedge clk);
        stall_mode = 1'b0;
        bp_mode    = 1'b0;
        // Quiet tail catches any stray extra beat
        repeat (10) @(negedge clk);
        $display("Checks: %0d, mismatches: %0d, other errors: %0d",
                 check_count, mismatch_count, other_errors);
        if (mismatch_count == 0 && other_errors == 0 && check_count > 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

/* list.f */
+incdir+sim
source/axird_pkg.sv
source/axird_burst_addr.sv
source/axird_req_issue.sv
source/axird_ctx_delay.sv
source/axird_skid_stage.sv
source/axird_resp_pipe.sv
source/axird_top.sv
sim/tb_axird.sv

/* run.sh */
#!/bin/sh
# Build the testbench with Verilator, run it, and pass only on the pass message
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f list.f --top-module tb_axird \
    -o tb_axird_sim \
    && ./obj_dir/tb_axird_sim | tee /dev/stderr | grep -q "^Finished with no errors$" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
